// ==== core_pipe_exec.sv ====
// ----------------------------------------------------------------------------
// Execute stage top level
// Decoder, ALU and commit logic wired together
// ----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module core_pipe_exec import exec_pkg::*; (
    input  logic      g_clk,            // Global clock
    input  logic      g_resetn,         // Sync reset, active low
    input  logic      s2_valid,         // Decode -> EX valid
    output logic      s2_ready,         // EX ready for instruction
    input  instr_t    s2_instr,         // Instruction word
    input  xlen_t     s2_pc,            // Program counter
    input  xlen_t     s2_rs1_data,      // RS1 value
    input  xlen_t     s2_rs2_data,      // RS2 value
    input  logic      s2_flush,         // Flush stage contents
    output logic      s2_cf_valid,      // Control-flow change
    input  logic      s2_cf_ack,        // Change acknowledged
    output xlen_t     s2_cf_target,     // Change destination
    output logic      s3_valid,         // Result to writeback
    input  logic      s3_ready,         // Writeback ready
    output logic      s3_full,          // Writeback holds instr
    output xlen_t     s3_pc,
    output instr_t    s3_instr,
    output reg_addr_t s3_rd,
    output logic      s3_wen,
    output xlen_t     s3_wdata
);

    alu_op_e   alu_op;
    cf_op_e    cf_op;
    xlen_t     alu_lhs;
    xlen_t     alu_rhs;
    xlen_t     imm;
    reg_addr_t rd;
    logic      rd_wen;
    xlen_t     alu_result;
    logic      cmp_eq;
    logic      cmp_lt;
    logic      cmp_ltu;

    exec_decode u_decode (
        .instr    (s2_instr),
        .rs1_data (s2_rs1_data),
        .rs2_data (s2_rs2_data),
        .alu_op   (alu_op),
        .cf_op    (cf_op),
        .alu_lhs  (alu_lhs),
        .alu_rhs  (alu_rhs),
        .imm      (imm),
        .rd       (rd),
        .rd_wen   (rd_wen)
    );

    exec_alu u_alu (
        .alu_op  (alu_op),
        .lhs     (alu_lhs),
        .rhs     (alu_rhs),
        .result  (alu_result),
        .cmp_eq  (cmp_eq),
        .cmp_lt  (cmp_lt),
        .cmp_ltu (cmp_ltu)
    );

    exec_commit u_commit (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .s2_valid     (s2_valid),
        .s2_flush     (s2_flush),
        .s3_ready     (s3_ready),
        .s2_cf_ack    (s2_cf_ack),
        .cf_op        (cf_op),
        .cmp_eq       (cmp_eq),
        .cmp_lt       (cmp_lt),
        .cmp_ltu      (cmp_ltu),
        .pc           (s2_pc),
        .rs1_data     (s2_rs1_data),
        .imm          (imm),
        .alu_result   (alu_result),
        .instr        (s2_instr),
        .rd           (rd),
        .rd_wen       (rd_wen),
        .s2_ready     (s2_ready),
        .s3_valid     (s3_valid),
        .s2_cf_valid  (s2_cf_valid),
        .s2_cf_target (s2_cf_target),
        .s3_full      (s3_full),
        .s3_pc        (s3_pc),
        .s3_instr     (s3_instr),
        .s3_rd        (s3_rd),
        .s3_wen       (s3_wen),
        .s3_wdata     (s3_wdata)
    );

endmodule

`default_nettype wire

// ==== exec_alu.sv ====
// ----------------------------------------------------------------------------
// Combinational ALU with shared add/sub adder
// Logic and shift results, branch comparisons of lhs against rhs
// ----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module exec_alu import exec_pkg::*; (
    input  alu_op_e alu_op,             // Operation select
    input  xlen_t   lhs,                // Left operand
    input  xlen_t   rhs,                // Right operand
    output xlen_t   result,             // Operation result
    output logic    cmp_eq,             // lhs == rhs
    output logic    cmp_lt,             // lhs <  rhs, signed
    output logic    cmp_ltu             // lhs <  rhs, unsigned
);

    logic          do_sub;              // Adder subtracts
    logic [XLEN:0] sum;                 // Adder out with carry
    logic [4:0]    shamt;

    // ------------------------------------------------------------------------
    // Shared adder, subtract is lhs + ~rhs + 1
    // ------------------------------------------------------------------------
    assign do_sub = (alu_op != ALU_ADD);
    assign sum    = {1'b0, lhs} + {1'b0, do_sub ? ~rhs : rhs} + {{XLEN{1'b0}}, do_sub};

    // Valid under subtract, which decode selects for branches
    assign cmp_eq  = (sum[XLEN-1:0] == '0);
    assign cmp_ltu = !sum[XLEN];                              // Borrow out
    assign cmp_lt  = (lhs[XLEN-1] == rhs[XLEN-1]) ? sum[XLEN-1] : lhs[XLEN-1];

    assign shamt = rhs[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD,
            ALU_SUB:  result = sum[XLEN-1:0];
            ALU_AND:  result = lhs & rhs;
            ALU_OR:   result = lhs | rhs;
            ALU_XOR:  result = lhs ^ rhs;
            ALU_SLL:  result = lhs << shamt;
            ALU_SRL:  result = lhs >> shamt;
            ALU_SRA:  result = xlen_t'($signed(lhs) >>> shamt);
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, cmp_lt};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, cmp_ltu};
            default:  result = sum[XLEN-1:0];
        endcase
    end

endmodule

`default_nettype wire

// ==== exec_checker.sv ====
// ----------------------------------------------------------------------------
// Handshake, flush and reset assertions for the execute stage
// Bound into the top level
// ----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module exec_checker (
    input logic g_clk,
    input logic g_resetn,
    input logic s2_valid,
    input logic s2_ready,
    input logic s2_flush,
    input logic s2_cf_valid,
    input logic s2_cf_ack,
    input logic s3_full
);

    a_cf_needs_valid : assert property (@(posedge g_clk) disable iff (!g_resetn)
        s2_cf_valid |-> s2_valid)
        else $error("s2_cf_valid high without a valid instruction");

    // Open request blocks the transfer
    a_cf_blocks_ready : assert property (@(posedge g_clk) disable iff (!g_resetn)
        (s2_cf_valid && !s2_cf_ack) |-> !s2_ready)
        else $error("s2_ready high while a request is unacknowledged");

    a_flush_empties : assert property (@(posedge g_clk) disable iff (!g_resetn)
        s2_flush |=> !s3_full)
        else $error("s3_full still high after a flush edge");

    a_reset_state : assert property (@(posedge g_clk)
        !g_resetn |=> (!s3_full && !s2_cf_valid))
        else $error("s3_full or s2_cf_valid high after reset");

endmodule

bind core_pipe_exec exec_checker u_checker (
    .g_clk       (g_clk),
    .g_resetn    (g_resetn),
    .s2_valid    (s2_valid),
    .s2_ready    (s2_ready),
    .s2_flush    (s2_flush),
    .s2_cf_valid (s2_cf_valid),
    .s2_cf_ack   (s2_cf_ack),
    .s3_full     (s3_full)
);

`default_nettype wire

// ==== exec_commit.sv ====
// ----------------------------------------------------------------------------
// Commit logic for the execute stage
// Branch resolution, control-flow request tracking, s2/s3 handshake
// Writeback pipeline register
// ----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module exec_commit import exec_pkg::*; (
    input  logic      g_clk,
    input  logic      g_resetn,
    input  logic      s2_valid,         // Instruction valid in s2
    input  logic      s2_flush,         // Flush stage contents
    input  logic      s3_ready,         // Writeback can accept
    input  logic      s2_cf_ack,        // Fetch took the request
    input  cf_op_e    cf_op,            // Decoded control-flow op
    input  logic      cmp_eq,
    input  logic      cmp_lt,
    input  logic      cmp_ltu,
    input  xlen_t     pc,               // s2 program counter
    input  xlen_t     rs1_data,         // JALR base
    input  xlen_t     imm,              // Branch / jump offset
    input  xlen_t     alu_result,
    input  instr_t    instr,
    input  reg_addr_t rd,
    input  logic      rd_wen,
    output logic      s2_ready,         // Stage takes new instruction
    output logic      s3_valid,         // Result offered to writeback
    output logic      s2_cf_valid,      // Control-flow change request
    output xlen_t     s2_cf_target,     // Request destination
    output logic      s3_full,          // s3 holds an instruction
    output xlen_t     s3_pc,
    output instr_t    s3_instr,
    output reg_addr_t s3_rd,
    output logic      s3_wen,
    output xlen_t     s3_wdata
);

    logic  taken;                       // Branch or jump redirects
    logic  is_jump;
    logic  cf_done;                     // Request already acked
    logic  cf_ok;                       // No request left open
    logic  xfer;                        // s2 -> s3 handshake
    xlen_t tgt_sum;
    xlen_t link;                        // pc + 4
    xlen_t wdata;

    // ------------------------------------------------------------------------
    // Branch resolution and target
    // ------------------------------------------------------------------------
    always_comb begin
        case (cf_op)
            CF_BEQ:  taken = cmp_eq;
            CF_BNE:  taken = !cmp_eq;
            CF_BLT:  taken = cmp_lt;
            CF_BGE:  taken = !cmp_lt;
            CF_BLTU: taken = cmp_ltu;
            CF_BGEU: taken = !cmp_ltu;
            CF_JAL,
            CF_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign is_jump      = (cf_op == CF_JAL) || (cf_op == CF_JALR);
    assign tgt_sum      = ((cf_op == CF_JALR) ? rs1_data : pc) + imm;
    assign s2_cf_target = {tgt_sum[XLEN-1:1], tgt_sum[0] && (cf_op != CF_JALR)};
    assign link         = pc + 32'd4;

    // ------------------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------------------
    assign s2_cf_valid = s2_valid && taken && !cf_done;
    assign cf_ok       = !taken || cf_done || s2_cf_ack;
    assign s2_ready    = s3_ready && cf_ok;
    assign s3_valid    = s2_valid && cf_ok;
    assign xfer        = s2_valid && s2_ready;

    // Holds off a second request while writeback stalls
    always_ff @(posedge g_clk) begin
        if (!g_resetn || s2_flush) begin
            cf_done <= 1'b0;
        end else if (xfer) begin
            cf_done <= 1'b0;                    // Next instruction starts clean
        end else if (s2_cf_valid && s2_cf_ack) begin
            cf_done <= 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Writeback register
    // ------------------------------------------------------------------------
    // Jumps link pc+4, ALU ops write the result, all else writes zero
    assign wdata = is_jump ? link : (rd_wen ? alu_result : '0);

    always_ff @(posedge g_clk) begin
        if (!g_resetn || s2_flush) begin
            s3_full <= 1'b0;
        end else if (xfer) begin
            s3_full <= 1'b1;
        end
    end

    always_ff @(posedge g_clk) begin
        if (xfer && !s2_flush) begin            // Flushed transfer is dropped
            s3_pc    <= pc;
            s3_instr <= instr;
            s3_rd    <= rd;
            s3_wen   <= rd_wen;
            s3_wdata <= wdata;
        end
    end

endmodule

`default_nettype wire

// ==== exec_decode.sv ====
// ----------------------------------------------------------------------------
// Instruction decoder for the execute stage
// Opcode/funct fields to ALU and control-flow ops, immediates, operands
// ----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module exec_decode import exec_pkg::*; (
    input  instr_t    instr,            // Instruction word in s2
    input  xlen_t     rs1_data,         // RS1 value
    input  xlen_t     rs2_data,         // RS2 value
    output alu_op_e   alu_op,           // ALU operation
    output cf_op_e    cf_op,            // Control-flow operation
    output xlen_t     alu_lhs,          // ALU left operand
    output xlen_t     alu_rhs,          // ALU right operand
    output xlen_t     imm,              // Selected immediate
    output reg_addr_t rd,               // Destination register
    output logic      rd_wen            // Register write, never x0
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_b;
    xlen_t      imm_j;
    logic       legal;                  // Supported encoding
    logic       writes;                 // Op class writes rd
    logic       rhs_imm;                // Right operand from immediate
    logic       alt;                    // sub / sra select

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // addi has no subtract form, so only OP or a shift picks the alt op
    assign alt = funct7[5] && ((opcode == OPC_OP) || (funct3 == 3'b101));

    always_comb begin
        alu_op  = ALU_ADD;
        cf_op   = CF_NONE;
        imm     = '0;
        legal   = 1'b0;
        writes  = 1'b0;
        rhs_imm = 1'b0;
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                writes  = 1'b1;
                rhs_imm = (opcode == OPC_OP_IMM);
                imm     = imm_i;
                if (opcode == OPC_OP) begin
                    legal = (funct7 == F7_BASE) ||
                            ((funct7 == F7_ALT) && (funct3 == 3'b000 || funct3 == 3'b101));
                end else if (funct3 == 3'b001) begin
                    legal = (funct7 == F7_BASE);            // slli
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                end else begin
                    legal = 1'b1;
                end
                case (funct3)
                    3'b000:  alu_op = alt ? ALU_SUB : ALU_ADD;
                    3'b001:  alu_op = ALU_SLL;
                    3'b010:  alu_op = ALU_SLT;
                    3'b011:  alu_op = ALU_SLTU;
                    3'b100:  alu_op = ALU_XOR;
                    3'b101:  alu_op = alt ? ALU_SRA : ALU_SRL;
                    3'b110:  alu_op = ALU_OR;
                    default: alu_op = ALU_AND;
                endcase
            end
            OPC_BRANCH: begin
                alu_op = ALU_SUB;               // Comparator runs off the adder
                imm    = imm_b;
                legal  = (funct3 != 3'b010) && (funct3 != 3'b011);
                case (funct3)
                    3'b000:  cf_op = CF_BEQ;
                    3'b001:  cf_op = CF_BNE;
                    3'b100:  cf_op = CF_BLT;
                    3'b101:  cf_op = CF_BGE;
                    3'b110:  cf_op = CF_BLTU;
                    default: cf_op = CF_BGEU;
                endcase
            end
            OPC_JAL: begin
                cf_op  = CF_JAL;
                imm    = imm_j;
                writes = 1'b1;
                legal  = 1'b1;
            end
            OPC_JALR: begin
                cf_op  = CF_JALR;
                imm    = imm_i;
                writes = 1'b1;
                legal  = (funct3 == 3'b000);
            end
            default: ;
        endcase
        if (!legal) begin                       // Unsupported, run as no-op
            alu_op = ALU_ADD;
            cf_op  = CF_NONE;
        end
    end

    assign rd_wen  = legal && writes && (rd != 5'd0);
    assign alu_lhs = rs1_data;
    assign alu_rhs = rhs_imm ? imm : rs2_data;

endmodule

`default_nettype wire

// ==== exec_pkg.sv ====
// ----------------------------------------------------------------------------
// Shared definitions for the RV32I execute stage
// Data widths, vector typedefs, major opcodes and funct7 codes
// ALU and control-flow operation enums
// ----------------------------------------------------------------------------
`default_nettype none

package exec_pkg;

    localparam int XLEN = 32;                   // Data and address width

    typedef logic [XLEN-1:0] xlen_t;            // Data or address word
    typedef logic [31:0]     instr_t;           // Raw instruction word
    typedef logic [4:0]      reg_addr_t;        // Register file index

    // ------------------------------------------------------------------------
    // Major opcodes recognised by the decoder
    // ------------------------------------------------------------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011;   // Reg-reg ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;   // Reg-imm ALU
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;   // Conditional branch
    localparam logic [6:0] OPC_JAL    = 7'b1101111;   // Jump and link
    localparam logic [6:0] OPC_JALR   = 7'b1100111;   // Jump and link reg

    localparam logic [6:0] F7_BASE    = 7'b0000000;   // Plain op
    localparam logic [6:0] F7_ALT     = 7'b0100000;   // sub / sra variant

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef enum logic [3:0] {
        CF_NONE,
        CF_BEQ,
        CF_BNE,
        CF_BLT,
        CF_BGE,
        CF_BLTU,
        CF_BGEU,
        CF_JAL,
        CF_JALR
    } cf_op_e;

endpackage

`default_nettype wire

// ==== tb_exec_model.svh ====
// ----------------------------------------------------------------------------
// Reference model of the RV32I execute stage
// Fibonacci LFSR random source for the testbench
// ----------------------------------------------------------------------------
`ifndef TB_EXEC_MODEL_SVH
`define TB_EXEC_MODEL_SVH

logic [15:0] lfsr_state;                            // Seeded by the testbench top

// Taps 16/14/13/11, maximal length
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        r = {r[30:0], lfsr_state[0]};
    end
    return r;
endfunction

// Expected writeback and control flow of one instruction
function automatic void model_exec(
    input  instr_t    instr,
    input  xlen_t     pc,
    input  xlen_t     rs1,
    input  xlen_t     rs2,
    output logic      wen,
    output reg_addr_t rd,
    output xlen_t     wdata,
    output logic      taken,
    output xlen_t     target
);
    logic [2:0]         f3;
    logic [6:0]         f7;
    logic signed [11:0] off_i;
    logic signed [12:0] off_b;
    logic signed [20:0] off_j;
    xlen_t              imm_i;
    xlen_t              imm_b;
    xlen_t              imm_j;
    xlen_t              b;
    xlen_t              res;
    logic               legal;
    logic               alt;
    f3     = instr[14:12];
    f7     = instr[31:25];
    rd     = instr[11:7];
    off_i  = instr[31:20];
    off_b  = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    off_j  = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    imm_i  = off_i;                                 // Signed offsets widen with sign
    imm_b  = off_b;
    imm_j  = off_j;
    wen    = 1'b0;
    wdata  = '0;
    taken  = 1'b0;
    target = '0;
    res    = '0;
    case (instr[6:0])
        OPC_OP, OPC_OP_IMM: begin
            b   = (instr[6:0] == OPC_OP) ? rs2 : imm_i;
            alt = (f7 == 7'h20) && ((instr[6:0] == OPC_OP) || (f3 == 3'd5));
            if (instr[6:0] == OPC_OP)
                legal = (f7 == 7'h00) || (alt && (f3 == 3'd0 || f3 == 3'd5));
            else if (f3 == 3'd1)
                legal = (f7 == 7'h00);              // slli
            else if (f3 == 3'd5)
                legal = (f7 == 7'h00) || alt;       // srli / srai
            else
                legal = 1'b1;
            case (f3)
                3'd0: res = alt ? rs1 - b : rs1 + b;
                3'd1: res = rs1 << b[4:0];
                3'd2: res = ($signed(rs1) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: res = (rs1 < b) ? 32'd1 : 32'd0;
                3'd4: res = rs1 ^ b;
                3'd5: begin
                    if (alt)
                        res = $signed(rs1) >>> b[4:0];
                    else
                        res = rs1 >> b[4:0];
                end
                3'd6: res = rs1 | b;
                default: res = rs1 & b;
            endcase
            wen   = legal && (rd != 5'd0);
            wdata = wen ? res : '0;
        end
        OPC_BRANCH: begin
            case (f3)
                3'd0: taken = (rs1 == rs2);
                3'd1: taken = (rs1 != rs2);
                3'd4: taken = ($signed(rs1) < $signed(rs2));
                3'd5: taken = ($signed(rs1) >= $signed(rs2));
                3'd6: taken = (rs1 < rs2);
                3'd7: taken = (rs1 >= rs2);
                default: taken = 1'b0;              // Reserved funct3
            endcase
            target = pc + imm_b;
        end
        OPC_JAL: begin
            taken  = 1'b1;
            target = pc + imm_j;
            wen    = (rd != 5'd0);
            wdata  = pc + 32'd4;                    // Link address
        end
        OPC_JALR: begin
            if (f3 == 3'd0) begin
                taken  = 1'b1;
                target = (rs1 + imm_i) & ~32'd1;    // Bit 0 dropped
                wen    = (rd != 5'd0);
                wdata  = pc + 32'd4;
            end
        end
        default: ;                                  // Unsupported, no effect
    endcase
endfunction

`endif

// ==== tb_core_pipe_exec.sv ====
// ----------------------------------------------------------------------------
// Testbench for the execute stage
// Clock, reset, random stimulus, scoreboard checks and watchdog
// ----------------------------------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

module tb_core_pipe_exec import exec_pkg::*; ();

    localparam int          CLK_PERIOD  = 8;
    localparam int          NUM_TXN     = 400;                  // Instructions to retire
    localparam int          WDOG_CYCLES = NUM_TXN * 20 + 100;
    localparam logic [15:0] LFSR_SEED   = 16'd56100;

    logic      g_clk;
    logic      g_resetn;
    logic      s2_valid;
    logic      s2_ready;
    instr_t    s2_instr;
    xlen_t     s2_pc;
    xlen_t     s2_rs1_data;
    xlen_t     s2_rs2_data;
    logic      s2_flush;
    logic      s2_cf_valid;
    logic      s2_cf_ack;
    xlen_t     s2_cf_target;
    logic      s3_valid;
    logic      s3_ready;
    logic      s3_full;
    xlen_t     s3_pc;
    instr_t    s3_instr;
    reg_addr_t s3_rd;
    logic      s3_wen;
    xlen_t     s3_wdata;

    // ------------------------------------------------------------------------
    // Scoreboard state
    // ------------------------------------------------------------------------
    logic      exp_full;                    // Expected s3_full
    logic      have_s3;                     // s3 registers loaded once
    xlen_t     exp_pc;
    instr_t    exp_instr;
    reg_addr_t exp_rd;
    logic      exp_wen;
    xlen_t     exp_wdata;
    string     s3_test;                     // Test of the retired instr
    string     cur_test;                    // Test of the s2 instr
    logic      req_done;                    // s2 request already acked
    logic      consumed;                    // s2 instr left at last edge
    logic      exp_cfv;
    logic      exp_ok;                      // No request left open
    logic      xfer;
    int        ack_count;
    int        retired;
    logic      m_wen;
    reg_addr_t m_rd;
    xlen_t     m_wdata;
    logic      m_taken;
    xlen_t     m_target;

    `include "tb_exec_model.svh"

    core_pipe_exec DUT (.*);

    initial g_clk = 1'b0;
    always #(CLK_PERIOD / 2) g_clk = ~g_clk;

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %h actual %h", name, exp, act);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic check_rd(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %0d actual %0d", name, exp, act);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %b actual %b", name, exp, act);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    task automatic new_instr();
        logic [3:0] kind;
        logic [2:0] f3;
        instr_t     w;
        xlen_t      a;
        kind = rand_bits(4);
        f3   = rand_bits(3);
        w    = rand_bits(32);                               // Random fields
        if (rand_bits(3) == 0)
            w[11:7] = 5'd0;                                 // x0 destination
        if (kind < 5) begin
            w[6:0]   = OPC_OP;
            w[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && rand_bits(1) != 0) ? F7_ALT : F7_BASE;
            cur_test = "alu_reg";
        end else if (kind < 9) begin
            w[6:0] = OPC_OP_IMM;
            if (f3 == 3'd1 || f3 == 3'd5)
                w[31:25] = (f3 == 3'd5 && rand_bits(1) != 0) ? F7_ALT : F7_BASE;
            cur_test = "alu_imm";
        end else if (kind < 12) begin
            w[6:0] = OPC_BRANCH;
            if (f3 == 3'd2 || f3 == 3'd3)
                f3 = f3 + 3'd2;                             // Skip reserved conditions
            cur_test = "branch";
        end else if (kind == 12) begin
            w[6:0]   = OPC_JAL;
            cur_test = "jal";
        end else if (kind == 13) begin
            w[6:0]   = OPC_JALR;
            f3       = 3'd0;
            cur_test = "jalr";
        end else if (kind == 14) begin
            w[6:0]   = OPC_OP;
            w[31:25] = 7'b0000001;                          // M extension is not decoded
            cur_test = "unsupported";
        end else begin
            cur_test = "random_word";
        end
        if (kind < 12 || kind == 13)
            w[14:12] = f3;
        a = rand_bits(32);
        s2_instr    <= w;
        s2_pc       <= rand_bits(30) << 2;
        s2_rs1_data <= a;
        s2_rs2_data <= (rand_bits(2) == 0) ? a : rand_bits(32);   // Equal operands too
    endtask

    task automatic drive_inputs();
        s2_flush  <= (rand_bits(5) == 0);                   // Rare flush
        s3_ready  <= (rand_bits(2) != 0);                   // Stall a quarter of cycles
        s2_cf_ack <= (rand_bits(1) != 0);
        if (!s2_valid || consumed) begin
            ack_count = 0;
            if (rand_bits(3) != 0) begin
                new_instr();
                s2_valid <= 1'b1;
            end else begin
                s2_valid <= 1'b0;
                cur_test = "idle";
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Checking and prediction between edges
    // ------------------------------------------------------------------------
    task automatic check_outputs();
        check_bit({s3_test, " s3_full"}, exp_full, s3_full);
        if (have_s3) begin
            check_word({s3_test, " s3_pc"}, exp_pc, s3_pc);
            check_word({s3_test, " s3_instr"}, exp_instr, s3_instr);
            check_rd({s3_test, " s3_rd"}, exp_rd, s3_rd);
            check_bit({s3_test, " s3_wen"}, exp_wen, s3_wen);
            check_word({s3_test, " s3_wdata"}, exp_wdata, s3_wdata);
        end
        if (s2_valid) begin
            model_exec(s2_instr, s2_pc, s2_rs1_data, s2_rs2_data,
                       m_wen, m_rd, m_wdata, m_taken, m_target);
            exp_cfv = m_taken && !req_done;
            exp_ok  = !m_taken || req_done || s2_cf_ack;
            check_bit({cur_test, " s2_cf_valid"}, exp_cfv, s2_cf_valid);
            if (exp_cfv)
                check_word({cur_test, " s2_cf_target"}, m_target, s2_cf_target);
            check_bit({cur_test, " s2_ready"}, s3_ready && exp_ok, s2_ready);
            check_bit({cur_test, " s3_valid"}, exp_ok, s3_valid);
        end else begin
            exp_cfv = 1'b0;
            exp_ok  = 1'b0;
            check_bit("idle s2_cf_valid", 1'b0, s2_cf_valid);
            check_bit("idle s3_valid", 1'b0, s3_valid);
        end
    endtask

    task automatic predict_edge();
        xfer     = s2_valid && s3_ready && exp_ok;
        consumed = s2_valid && (xfer || s2_flush);
        if (s2_cf_valid && s2_cf_ack)                       // Requests the DUT saw acked
            ack_count++;
        if (xfer)                                           // One request per taken instr
            check_bit({cur_test, " request count"}, 1'b1, ack_count == (m_taken ? 1 : 0));
        if (s2_flush) begin
            exp_full = 1'b0;
            req_done = 1'b0;
            s3_test  = "flush";
        end else if (xfer) begin
            exp_full  = 1'b1;
            have_s3   = 1'b1;
            exp_pc    = s2_pc;
            exp_instr = s2_instr;
            exp_rd    = m_rd;
            exp_wen   = m_wen;
            exp_wdata = m_wdata;
            s3_test   = cur_test;
            req_done  = 1'b0;
        end else if (exp_cfv && s2_cf_ack) begin
            req_done = 1'b1;
        end
        if (consumed)
            retired++;
    endtask

    initial begin
        lfsr_state  = LFSR_SEED;
        g_resetn    = 1'b0;
        s2_valid    = 1'b0;
        s2_instr    = '0;
        s2_pc       = '0;
        s2_rs1_data = '0;
        s2_rs2_data = '0;
        s2_flush    = 1'b0;
        s2_cf_ack   = 1'b0;
        s3_ready    = 1'b0;
        exp_full    = 1'b0;
        have_s3     = 1'b0;
        req_done    = 1'b0;
        consumed    = 1'b0;
        ack_count   = 0;
        retired     = 0;
        cur_test    = "idle";
        s3_test     = "reset";
        repeat (3) @(posedge g_clk);
        g_resetn <= 1'b1;
        while (retired < NUM_TXN) begin
            @(negedge g_clk);
            check_outputs();
            predict_edge();
            @(posedge g_clk);
            drive_inputs();
        end
        @(negedge g_clk);
        check_outputs();
        $display("Regression passed");
        $finish;
    end

    // Bound on run length from the instruction count
    initial begin
        #(WDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: only %0d of %0d instructions retired", retired, NUM_TXN);
        $display("Regression failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
exec_pkg.sv
exec_decode.sv
exec_alu.sv
exec_commit.sv
core_pipe_exec.sv
exec_checker.sv
tb_core_pipe_exec.sv
